// File: Makefile
# controller sniffer simulation with Verilator

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_n64_ctrl
RTL_TOP  = n64_ctrl_top
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Test failed
PASS_MSG = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# a run without the pass line (crash, assertion stop) also counts as a failure
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
design/n64_ctrl_pkg.sv
design/ctrl_bit_decoder.sv
design/ctrl_frame_sniffer.sv
design/igr_reset_gen.sv
design/vsync_cfg_latch.sv
design/n64_ctrl_top.sv
tb/tb_n64_ctrl.sv

// File: design/ctrl_bit_decoder.sv
/*
  controller line bit decoder
  input history with edge pulses, saturating pulse counter,
  low length store and bit decision against the high length
*/
`timescale 1ns/1ps

module ctrl_bit_decoder import n64_ctrl_pkg::*; (
  input  logic VCLK,
  input  logic nSRST_4M,
  input  logic ctrl,       // controller line, listen only
  output logic line_fall,
  output logic line_rise,
  output logic bit_val,    // valid with line_fall
  output logic idle_full   // counter saturated
);

  logic [2:0] ctrl_hist;   // edges seen on [2:1]
  pulse_cnt_t pulse_cnt;   // cycles since last edge
  pulse_cnt_t low_len;     // low phase of current bit

  ////////////////////////////////////////
  // edge detection
  ////////////////////////////////////////

  assign line_fall =  ctrl_hist[2] & ~ctrl_hist[1];
  assign line_rise = ~ctrl_hist[2] &  ctrl_hist[1];

  ////////////////////////////////////////
  // pulse width measurement
  ////////////////////////////////////////

  assign idle_full = (pulse_cnt == IDLE_SAT);

  // at a fall the counter holds the high length of the bit that ended
  // short low and long high means a one
  assign bit_val = (low_len < pulse_cnt);

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      ctrl_hist <= 3'b111;    // line idles high
      pulse_cnt <= '0;
      low_len   <= '0;
    end else begin
      ctrl_hist <= {ctrl_hist[1:0], ctrl};

      if (line_fall || line_rise) begin
        pulse_cnt <= '0;      // restart on any edge
      end else if (!idle_full) begin
        pulse_cnt <= pulse_cnt + 1'b1;
      end                     // else hold at saturation

      if (line_rise) begin
        low_len <= pulse_cnt; // low phase just ended
      end
    end
  end

  // both edges from one history pair
  a_edges_excl: assert property (
    @(posedge VCLK) disable iff (!nSRST_4M)
    !(line_fall && line_rise)
  ) else $error("line_fall and line_rise high together");

endmodule

// File: design/ctrl_frame_sniffer.sv
/*
  controller frame sniffer
  FSM over console command and controller response,
  poll command filter, response assembly and frame_done strobe
*/
`timescale 1ns/1ps

module ctrl_frame_sniffer import n64_ctrl_pkg::*; (
  input  logic       VCLK,
  input  logic       nSRST_4M,
  input  logic       line_fall,
  input  logic       bit_val,
  input  logic       idle_full,
  output ctrl_word_t ctrl_data,   // last complete response
  output logic       frame_done   // one cycle strobe
);

  sniff_state_t          state;
  logic [BITCNT_W-1:0]   bit_cnt;
  logic [CMD_BITS-1:0]   cmd_sr;   // command, msb first
  logic [RESP_BITS-1:0]  resp_sr;  // response, lsb first
  logic                  shift_cmd;
  logic                  shift_resp;

  // first fall of the frame carries no bit, later falls end one
  assign shift_cmd  = (state == st_n64_rd) && line_fall &&
                      (bit_cnt < BITCNT_W'(CMD_BITS));
  assign shift_resp = (state == st_ctrl_rd) && line_fall;

  ////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////

  always_ff @(posedge VCLK) begin
    if (shift_cmd) begin
      cmd_sr <= {cmd_sr[CMD_BITS-2:0], bit_val};
    end
    if (shift_resp) begin
      resp_sr <= {bit_val, resp_sr[RESP_BITS-1:1]};
    end
  end

  ////////////////////////////////////////
  // frame FSM
  ////////////////////////////////////////

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      state      <= st_wait4n64;
      bit_cnt    <= '0;
      ctrl_data  <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      case (state)
        st_wait4n64: begin
          if (idle_full && line_fall) begin  // start bit after long idle
            state   <= st_n64_rd;
            bit_cnt <= '0;
          end
        end
        st_n64_rd: begin
          if (idle_full) begin
            state <= st_wait4n64;            // line stalled
          end else if (line_fall) begin
            if (shift_cmd) begin
              bit_cnt <= bit_cnt + 1'b1;
            end else if (cmd_sr == POLL_CMD) begin  // stop bit ended
              state   <= st_ctrl_rd;
              bit_cnt <= '0;
            end else begin
              state <= st_wait4n64;          // not a poll, ignore reply
            end
          end
        end
        st_ctrl_rd: begin
          if (idle_full) begin
            state <= st_wait4n64;            // reply cut off
          end else if (line_fall) begin
            if (bit_cnt == BITCNT_W'(RESP_BITS - 1)) begin
              state      <= st_wait4n64;
              ctrl_data  <= {bit_val, resp_sr[RESP_BITS-1:1]};
              frame_done <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: state <= st_wait4n64;
      endcase
    end
  end

  // a completed frame always comes out of the response phase
  a_done_in_resp: assert property (
    @(posedge VCLK) disable iff (!nSRST_4M)
    frame_done |-> $past(state == st_ctrl_rd && line_fall)
  ) else $error("frame_done outside response phase");

endmodule

// File: design/igr_reset_gen.sv
/*
  in-game reset generator
  button combination compare on new responses
  and reset hold counter driving the active low request
*/
`timescale 1ns/1ps

module igr_reset_gen import n64_ctrl_pkg::*; (
  input  logic       VCLK,
  input  logic       nSRST_4M,
  input  logic       frame_done,
  input  ctrl_word_t ctrl_data,
  input  logic       use_igr,
  output logic       nrst_req    // active low
);

  rst_cnt_t rst_cnt;    // cycles left in hold
  logic     igr_match;

  // stick bytes ignored
  assign igr_match = frame_done && use_igr && (ctrl_data[15:0] == IGR_RESET);

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      rst_cnt  <= '0;
      nrst_req <= 1'b1;
    end else begin
      if (igr_match) begin
        rst_cnt  <= RST_HOLD;       // (re)start hold
        nrst_req <= 1'b0;
      end else if (rst_cnt != '0) begin
        rst_cnt <= rst_cnt - 1'b1;
      end else begin
        nrst_req <= 1'b1;           // hold over
      end
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // empty counter with request low only on the last hold cycle
  a_hold_loaded: assert property (
    @(posedge VCLK) disable iff (!nSRST_4M)
    (!nrst_req && rst_cnt == '0) |-> $past(rst_cnt) == rst_cnt_t'(1)
  ) else $error("reset request low without a loaded hold");

endmodule

// File: design/n64_ctrl_pkg.sv
/*
  controller sniffer package
  widths and their vector typedefs, sniffer FSM states,
  poll command, IGR combination, reset hold length,
  and bit positions inside the system config word
*/
package n64_ctrl_pkg;

  // widths
  localparam int CTRL_W  = 32;  // controller response
  localparam int CFG_W   = 32;  // system config word
  localparam int PPU_W   = 16;  // ppu config slice
  localparam int PULSE_W = 6;   // pulse length counter
  localparam int RST_W   = 10;  // reset hold counter

  typedef logic [CTRL_W-1:0]  ctrl_word_t;
  typedef logic [CFG_W-1:0]   cfg_word_t;
  typedef logic [PPU_W-1:0]   ppu_cfg_t;
  typedef logic [PULSE_W-1:0] pulse_cnt_t;
  typedef logic [RST_W-1:0]   rst_cnt_t;

  typedef enum logic [1:0] {
    st_wait4n64 = 2'b00,  // wait for idle line
    st_n64_rd   = 2'b01,  // console command
    st_ctrl_rd  = 2'b10   // controller response
  } sniff_state_t;

  // framing
  localparam pulse_cnt_t IDLE_SAT = 6'd63;  // line idle long enough to arm
  localparam int CMD_BITS  = 8;
  localparam int RESP_BITS = 32;
  localparam int BITCNT_W  = $clog2(RESP_BITS);
  localparam logic [CMD_BITS-1:0] POLL_CMD = 8'h01;

  // L, R, Z and Start held
  localparam logic [15:0] IGR_RESET = 16'h0c0c;
  localparam rst_cnt_t    RST_HOLD  = 10'd1023;  // in VCLK cycles

  // config word layout
  localparam int CFG_USE_VPLL  = 31;
  localparam int CFG_TEST_VPLL = 30;
  localparam int CFG_SHOW_OSD  = 29;
  localparam int CFG_MUTE_OSD  = 28;
  localparam int CFG_SHOW_LOGO = 27;
  localparam int CFG_IGR_EN    = 26;
  localparam int CFG_PPU_LSB   = 0;   // ppu slice in 15:0

endpackage

// File: design/n64_ctrl_top.sv
/*
  controller sniffer top level
  bit decoder, frame sniffer, IGR reset generator
  and frame synchronous config latch
*/
`timescale 1ns/1ps

module n64_ctrl_top import n64_ctrl_pkg::*; (
  input  logic       VCLK,
  input  logic       nSRST_4M,
  input  logic       ctrl,
  input  logic       nvdsync,
  input  logic       vd_vsi,
  input  cfg_word_t  cfg_word,
  output logic [1:0] manage_vpll,
  output logic [1:0] osd_info,
  output ppu_cfg_t   ppu_cfg,
  output ctrl_word_t ctrl_data,
  output logic       new_ctrl_data,
  output logic       nrst_req
);

  logic line_fall;
  logic bit_val;
  logic idle_full;
  logic frame_done;
  logic use_igr;

  ctrl_bit_decoder u_bit_dec (
    .VCLK      (VCLK),
    .nSRST_4M  (nSRST_4M),
    .ctrl      (ctrl),
    .line_fall (line_fall),
    .line_rise (),            // consumed inside the decoder
    .bit_val   (bit_val),
    .idle_full (idle_full)
  );

  ctrl_frame_sniffer u_sniffer (
    .VCLK       (VCLK),
    .nSRST_4M   (nSRST_4M),
    .line_fall  (line_fall),
    .bit_val    (bit_val),
    .idle_full  (idle_full),
    .ctrl_data  (ctrl_data),
    .frame_done (frame_done)
  );

  igr_reset_gen u_igr (
    .VCLK       (VCLK),
    .nSRST_4M   (nSRST_4M),
    .frame_done (frame_done),
    .ctrl_data  (ctrl_data),
    .use_igr    (use_igr),
    .nrst_req   (nrst_req)
  );

  vsync_cfg_latch u_cfg (
    .VCLK          (VCLK),
    .nSRST_4M      (nSRST_4M),
    .nvdsync       (nvdsync),
    .vd_vsi        (vd_vsi),
    .cfg_word      (cfg_word),
    .frame_done    (frame_done),
    .manage_vpll   (manage_vpll),
    .osd_info      (osd_info),
    .ppu_cfg       (ppu_cfg),
    .use_igr       (use_igr),
    .new_ctrl_data (new_ctrl_data)
  );

endmodule

// File: design/vsync_cfg_latch.sv
/*
  frame synchronous config latch
  vsync falling edge detect qualified by nvdsync,
  config decode to vpll, osd, ppu and igr enable,
  new controller data flag
*/
`timescale 1ns/1ps

module vsync_cfg_latch import n64_ctrl_pkg::*; (
  input  logic       VCLK,
  input  logic       nSRST_4M,
  input  logic       nvdsync,        // sync enable, active low
  input  logic       vd_vsi,
  input  cfg_word_t  cfg_word,
  input  logic       frame_done,
  output logic [1:0] manage_vpll,    // {use, test}
  output logic [1:0] osd_info,       // {logo, osd}
  output ppu_cfg_t   ppu_cfg,
  output logic       use_igr,
  output logic       new_ctrl_data
);

  logic vsync_cur;   // last vd_vsi seen with nvdsync low
  logic vsync_neg;   // one cycle edge pulse

  ////////////////////////////////////////
  // vsync edge
  ////////////////////////////////////////

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      vsync_cur <= 1'b0;
      vsync_neg <= 1'b0;
    end else begin
      vsync_neg <= ~nvdsync & vsync_cur & ~vd_vsi;
      if (!nvdsync) begin
        vsync_cur <= vd_vsi;   // only qualified samples
      end
    end
  end

  ////////////////////////////////////////
  // config latch and data flag
  ////////////////////////////////////////

  always_ff @(posedge VCLK or negedge nSRST_4M) begin
    if (!nSRST_4M) begin
      manage_vpll   <= '0;
      osd_info      <= '0;
      ppu_cfg       <= '0;
      use_igr       <= 1'b0;
      new_ctrl_data <= 1'b0;
    end else begin
      if (vsync_neg) begin   // between frames only
        manage_vpll <= {cfg_word[CFG_USE_VPLL], cfg_word[CFG_TEST_VPLL]};
        osd_info[0] <= cfg_word[CFG_SHOW_OSD] & ~cfg_word[CFG_MUTE_OSD];
        osd_info[1] <= cfg_word[CFG_SHOW_OSD] & cfg_word[CFG_SHOW_LOGO] &
                       ~cfg_word[CFG_MUTE_OSD];  // logo inside osd only
        ppu_cfg     <= cfg_word[CFG_PPU_LSB +: PPU_W];
        use_igr     <= cfg_word[CFG_IGR_EN];
      end

      if (frame_done) begin
        new_ctrl_data <= 1'b1;  // fresh response wins over the edge
      end else if (vsync_neg) begin
        new_ctrl_data <= 1'b0;
      end
    end
  end

endmodule

// File: tb/tb_n64_ctrl.sv
/*
  directed testbench for the controller sniffer top level
  controller line bit banging, vsync pulses, LFSR response words,
  typed compare tasks and a watchdog
*/
`timescale 1ns/1ps

module tb_n64_ctrl import n64_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int IDLE_CYC   = 70;   // line high ahead of each frame
  localparam int BIT_CYC    = 16;   // low plus high phase
  localparam int FRAME_CYC  = IDLE_CYC + (CMD_BITS + 1 + RESP_BITS + 1) * BIT_CYC;
  localparam int N_FRAMES   = 9;
  localparam int WATCHDOG_CYC = (N_FRAMES * FRAME_CYC + int'(RST_HOLD)) * 2;
  localparam logic [31:0] LFSR_SEED = 32'h024527e3;
  localparam logic [7:0]  CMD_POLL  = 8'h01;
  localparam logic [7:0]  CMD_OTHER = 8'h02;   // not a poll
  // Z bit 2, Start bit 3, L bit 10, R bit 11
  localparam logic [15:0] IGR_COMBO = 16'h0004 | 16'h0008 | 16'h0400 | 16'h0800;

  logic       VCLK;
  logic       nSRST_4M;
  logic       ctrl;
  logic       nvdsync;
  logic       vd_vsi;
  cfg_word_t  cfg_word;
  logic [1:0] manage_vpll;
  logic [1:0] osd_info;
  ppu_cfg_t   ppu_cfg;
  ctrl_word_t ctrl_data;
  logic       new_ctrl_data;
  logic       nrst_req;

  logic [31:0] lfsr;        // random state
  ctrl_word_t  last_word;   // last response that should be captured
  logic [1:0]  exp_vpll;    // config outputs expected now
  logic [1:0]  exp_osd;
  ppu_cfg_t    exp_ppu;

  n64_ctrl_top DUT (
    .VCLK          (VCLK),
    .nSRST_4M      (nSRST_4M),
    .ctrl          (ctrl),
    .nvdsync       (nvdsync),
    .vd_vsi        (vd_vsi),
    .cfg_word      (cfg_word),
    .manage_vpll   (manage_vpll),
    .osd_info      (osd_info),
    .ppu_cfg       (ppu_cfg),
    .ctrl_data     (ctrl_data),
    .new_ctrl_data (new_ctrl_data),
    .nrst_req      (nrst_req)
  );

  initial begin
    VCLK = 1'b0;
    forever #(CLK_PERIOD / 2) VCLK = ~VCLK;
  end

  initial begin   // frames, reset hold and slack
    #(WATCHDOG_CYC * CLK_PERIOD);
    report_fail("timeout: the tests did not finish in time");
  end

  ////////////////////////////////////////
  // reporting and compares
  ////////////////////////////////////////

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_ctrl(input string name, input ctrl_word_t exp, input ctrl_word_t act);
    if (act !== exp) report_fail($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cfg(input string name, input ppu_cfg_t exp, input ppu_cfg_t act);
    if (act !== exp) report_fail($sformatf("Error in %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_bits(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) report_fail($sformatf("Error in %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) report_fail($sformatf("Error in %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the lsb
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_word(output ctrl_word_t w);
    for (int i = 0; i < RESP_BITS; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];   // one step per bit
    end
  endtask

  task automatic send_bit(input logic b);
    ctrl = 1'b0;
    repeat (b ? 4 : 12) @(negedge VCLK);   // short low is a one
    ctrl = 1'b1;
    repeat (b ? 12 : 4) @(negedge VCLK);
  endtask

  // n_resp below RESP_BITS leaves the reply cut off, no stop bit
  task automatic send_frame(input logic [7:0] cmd, input ctrl_word_t resp, input int n_resp);
    ctrl = 1'b1;
    repeat (IDLE_CYC) @(negedge VCLK);
    for (int i = CMD_BITS - 1; i >= 0; i--) begin
      send_bit(cmd[i]);                    // msb first
    end
    send_bit(1'b1);                        // console stop bit
    for (int i = 0; i < n_resp; i++) begin
      send_bit(resp[i]);                   // lsb first
    end
    if (n_resp == RESP_BITS) begin
      send_bit(1'b1);                      // controller stop bit
    end
  endtask

  task automatic pulse_vsync();
    nvdsync = 1'b0;
    vd_vsi  = 1'b1;
    repeat (2) @(negedge VCLK);
    vd_vsi  = 1'b0;                        // qualified falling edge
    repeat (4) @(negedge VCLK);
    nvdsync = 1'b1;
  endtask

  task automatic wait_new_data(input string name);
    int n;
    n = 0;
    while (new_ctrl_data !== 1'b1 && n < 4 * BIT_CYC) begin
      @(negedge VCLK);
      n++;
    end
    if (new_ctrl_data !== 1'b1) report_fail({name, ": new data flag never rose after the frame"});
  endtask

  // held outputs first, then the decoded word after the edge
  task automatic apply_cfg(input string name, input cfg_word_t cfg,
                           input logic [1:0] vpll, input logic [1:0] osd);
    cfg_word = cfg;
    repeat (20) @(negedge VCLK);
    check_bits({name, " vpll held"}, exp_vpll, manage_vpll);
    check_bits({name, " osd held"}, exp_osd, osd_info);
    check_cfg({name, " ppu held"}, exp_ppu, ppu_cfg);
    pulse_vsync();
    exp_vpll = vpll;
    exp_osd  = osd;
    exp_ppu  = cfg[15:0];
    check_bits({name, " vpll"}, exp_vpll, manage_vpll);
    check_bits({name, " osd"}, exp_osd, osd_info);
    check_cfg({name, " ppu"}, exp_ppu, ppu_cfg);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_reset();
    check_level("reset nrst_req", 1'b1, nrst_req);
    check_level("reset new data", 1'b0, new_ctrl_data);
    check_ctrl("reset ctrl_data", '0, ctrl_data);
    check_cfg("reset ppu_cfg", '0, ppu_cfg);
    check_bits("reset osd_info", 2'b00, osd_info);
    check_bits("reset manage_vpll", 2'b00, manage_vpll);
  endtask

  task automatic test_poll_capture();
    ctrl_word_t w;
    string      name;
    for (int f = 0; f < 4; f++) begin
      name = $sformatf("poll capture %0d", f);
      next_word(w);
      send_frame(CMD_POLL, w, RESP_BITS);
      wait_new_data(name);
      check_ctrl(name, w, ctrl_data);
      last_word = w;
      pulse_vsync();
      check_level({name, " flag after vsync"}, 1'b0, new_ctrl_data);
    end
  endtask

  task automatic test_cmd_filter();
    ctrl_word_t w;
    next_word(w);
    send_frame(CMD_OTHER, w, RESP_BITS);
    repeat (8) @(negedge VCLK);
    check_ctrl("command filter", last_word, ctrl_data);
    check_level("command filter flag", 1'b0, new_ctrl_data);
  endtask

  task automatic test_stall_abort();
    ctrl_word_t w;
    next_word(w);
    send_frame(CMD_POLL, w, 10);
    repeat (int'(IDLE_SAT) + 16) @(negedge VCLK);   // line parked high
    check_ctrl("stall abort", last_word, ctrl_data);
    check_level("stall abort flag", 1'b0, new_ctrl_data);
    next_word(w);
    send_frame(CMD_POLL, w, RESP_BITS);
    wait_new_data("frame after stall");
    check_ctrl("frame after stall", w, ctrl_data);
    last_word = w;
    pulse_vsync();
  endtask

  task automatic test_cfg_sync();
    apply_cfg("vpll and osd", 32'ha000_1234, 2'b10, 2'b01);
    apply_cfg("osd muted", 32'h7800_abcd, 2'b01, 2'b00);
    apply_cfg("logo without osd", 32'h8800_5a5a, 2'b10, 2'b00);
    apply_cfg("osd with logo", 32'he800_0f0f, 2'b11, 2'b11);
  endtask

  // drop seen at k = 0, low up to k = RST_HOLD, high from RST_HOLD+1
  task automatic watch_reset_hold();
    int n;
    n = 0;
    while (nrst_req !== 1'b0 && n < 2 * FRAME_CYC) begin
      @(negedge VCLK);
      n++;
    end
    if (nrst_req !== 1'b0) report_fail("reset request never went low after the IGR frame");
    repeat (int'(RST_HOLD) - 1) @(negedge VCLK);
    check_level("igr hold end", 1'b0, nrst_req);
    repeat (3) @(negedge VCLK);
    check_level("igr release", 1'b1, nrst_req);
  endtask

  task automatic test_igr();
    ctrl_word_t igr_word;
    igr_word = {16'h7f81, IGR_COMBO};        // stick bytes are don't care
    send_frame(CMD_POLL, igr_word, RESP_BITS);   // igr still off
    wait_new_data("igr disabled");
    check_ctrl("igr disabled", igr_word, ctrl_data);
    for (int i = 0; i < 16; i++) begin
      check_level("igr disabled", 1'b1, nrst_req);
      @(negedge VCLK);
    end
    apply_cfg("igr enable", 32'h0400_0000, 2'b00, 2'b00);
    fork
      send_frame(CMD_POLL, igr_word, RESP_BITS);
      watch_reset_hold();
    join
    check_ctrl("igr enabled", igr_word, ctrl_data);
  endtask

  initial begin
    nSRST_4M  = 1'b0;
    ctrl      = 1'b1;        // idle high
    nvdsync   = 1'b1;
    vd_vsi    = 1'b0;
    cfg_word  = '0;
    lfsr      = LFSR_SEED;
    last_word = '0;
    exp_vpll  = 2'b00;
    exp_osd   = 2'b00;
    exp_ppu   = '0;
    repeat (4) @(negedge VCLK);
    nSRST_4M  = 1'b1;
    test_reset();
    test_poll_capture();
    test_cmd_filter();
    test_stall_abort();
    test_cfg_sync();
    test_igr();
    $display("Test completed successfully");
    $finish;
  end

endmodule
